// ==== hw/iobus_config.svh ====
`ifndef IOBUS_CONFIG_SVH
`define IOBUS_CONFIG_SVH

// top bit of the command byte
`define IOBUS_MSG_REQ	1'b1
`define IOBUS_MSG_RESP	1'b0

// request codes
`define IOBUS_CMD_PA	4'b0000
`define IOBUS_CMD_CL	4'b0001
`define IOBUS_CMD_W	4'b0010
`define IOBUS_CMD_R	4'b0011
`define IOBUS_CMD_IN	4'b0110

// response codes, share values with the requests
`define IOBUS_CMD_EN	4'b0001
`define IOBUS_CMD_OK	4'b0010
`define IOBUS_CMD_PE	4'b0011

// requests to this half of the address space never leave the bus
`define IOBUS_LOCAL_ADDR_BIT	15

`endif

// ==== hw/iobus_pkg.sv ====
`include "iobus_config.svh"

package iobus_pkg;

	typedef struct packed {
		logic [7:0] cmd;	// type bit, code, 3'b000
		logic [7:0] a1;	// 2'b00, qb, pn, nb
		logic [15:0] a2;	// address
		logic [15:0] a3;	// data
	} msg_t;

	typedef struct packed {
		logic rs;
		logic rf;
		logic rok;
		logic rpe;
		logic rqb;
		logic rpn;
		logic [3:0] rnb;
		logic [15:0] rad;
		logic [15:0] rdt;
	} bus_in_t;

	typedef struct packed {
		logic dpa;
		logic dw;
		logic dr;
		logic din;
		logic dok;
		logic den;
		logic dpe;
		logic dpn;
		logic [3:0] dnb;
		logic [15:0] dad;
		logic [15:0] ddt;
	} bus_out_t;

	typedef struct packed {
		logic req;
		logic valid;
		logic pa;
		logic w;
		logic r;
		logic in;
		logic ok;
		logic en;
		logic pe;
		logic cl;
	} cmd_flags_t;

	// argument bytes that follow a command byte
	function automatic logic [2:0] msg_arg_len(input logic [7:0] cmd);
		logic [3:0] code;
		code = cmd[6:3];
		if (cmd[7] == `IOBUS_MSG_REQ) begin
			case (code)
				`IOBUS_CMD_PA: return 3'd1;
				`IOBUS_CMD_W: return 3'd5;
				`IOBUS_CMD_R, `IOBUS_CMD_IN: return 3'd3;
				default: return 3'd0;
			endcase
		end
		if (code == `IOBUS_CMD_OK)
			return 3'd2;
		return 3'd0;
	endfunction

	// first argument slot on the wire, OK skips a1 and a2
	function automatic logic [2:0] msg_arg_first(input logic [7:0] cmd);
		if (cmd[7] == `IOBUS_MSG_RESP && cmd[6:3] == `IOBUS_CMD_OK)
			return 3'd3;
		return 3'd0;
	endfunction

endpackage

// ==== hw/cmd_codec.sv ====
`include "iobus_config.svh"

module cmd_codec (
	input iobus_pkg::bus_in_t bus_in,
	input logic [7:0] rx_cmd,
	output logic [7:0] local_cmd,
	output iobus_pkg::cmd_flags_t rx_flags
);

	logic rx_req;
	logic [3:0] rx_code;
	logic fmt_ok;

	// outgoing command from local bus activity
	always_comb begin
		if (bus_in.rs)
			local_cmd = {`IOBUS_MSG_REQ, `IOBUS_CMD_W, 3'b000};	// store
		else if (bus_in.rf)
			local_cmd = {`IOBUS_MSG_REQ, `IOBUS_CMD_R, 3'b000};	// fetch
		else if (bus_in.rok)
			local_cmd = {`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 3'b000};
		else if (bus_in.rpe)
			local_cmd = {`IOBUS_MSG_RESP, `IOBUS_CMD_PE, 3'b000};
		else
			local_cmd = 8'd0;
	end

	assign rx_req = rx_cmd[7];
	assign rx_code = rx_cmd[6:3];
	assign fmt_ok = (rx_cmd[2:0] == 3'b000);	// low bits must be clear

	// received command decode
	always_comb begin
		rx_flags = '0;
		rx_flags.req = rx_req;
		if (rx_req == `IOBUS_MSG_REQ) begin
			rx_flags.pa = (rx_code == `IOBUS_CMD_PA);
			rx_flags.cl = (rx_code == `IOBUS_CMD_CL);
			rx_flags.w = (rx_code == `IOBUS_CMD_W);
			rx_flags.r = (rx_code == `IOBUS_CMD_R);
			rx_flags.in = (rx_code == `IOBUS_CMD_IN);
		end else begin
			rx_flags.en = (rx_code == `IOBUS_CMD_EN);
			rx_flags.ok = (rx_code == `IOBUS_CMD_OK);
			rx_flags.pe = (rx_code == `IOBUS_CMD_PE);
		end
		rx_flags.valid = fmt_ok & (rx_flags.pa | rx_flags.cl | rx_flags.w | rx_flags.r
			| rx_flags.in | rx_flags.en | rx_flags.ok | rx_flags.pe);
	end

endmodule

// ==== hw/msg_rx.sv ====
module msg_rx (
	input logic clk_sys,
	input logic cl_reset,
	input logic [7:0] rx_byte,
	input logic rx_strobe,
	input logic rx_clear,
	output iobus_pkg::msg_t rx_msg,
	output logic rx_done,
	output logic rx_busy
);
	import iobus_pkg::*;

	logic held;	// complete message waiting for rx_clear
	logic accept;
	logic [2:0] first_len;
	logic [2:0] left;	// argument bytes still expected
	logic [2:0] slot;	// next argument slot
	logic [7:0] cmd_q;
	logic [7:0] a1_q;
	logic [15:0] a2_q;
	logic [15:0] a3_q;

	// a clear in the same cycle frees the receiver for this byte
	assign accept = rx_strobe & (~held | rx_clear);
	assign first_len = msg_arg_len(rx_byte);
	assign rx_msg = {cmd_q, a1_q, a2_q, a3_q};

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			held <= 1'b0;
			rx_busy <= 1'b0;
			rx_done <= 1'b0;
			left <= 3'd0;
			slot <= 3'd0;
			cmd_q <= 8'd0;
		end else begin
			rx_done <= 1'b0;
			if (rx_clear)
				held <= 1'b0;
			if (accept) begin
				if (!rx_busy) begin
					cmd_q <= rx_byte;	// command byte
					left <= first_len;
					slot <= msg_arg_first(rx_byte);
					if (first_len == 3'd0) begin
						held <= 1'b1;
						rx_done <= 1'b1;
					end else begin
						rx_busy <= 1'b1;
					end
				end else begin
					left <= left - 3'd1;
					slot <= slot + 3'd1;
					if (left == 3'd1) begin	// last argument
						rx_busy <= 1'b0;
						held <= 1'b1;
						rx_done <= 1'b1;
					end
				end
			end
		end
	end

	// argument bytes land in wire order
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (!rx_busy) begin
				a1_q <= 8'd0;
				a2_q <= 16'd0;
				a3_q <= 16'd0;
			end else begin
				case (slot)
					3'd0: a1_q <= rx_byte;
					3'd1: a2_q[15:8] <= rx_byte;
					3'd2: a2_q[7:0] <= rx_byte;
					3'd3: a3_q[15:8] <= rx_byte;
					default: a3_q[7:0] <= rx_byte;
				endcase
			end
		end
	end

endmodule

// ==== hw/msg_tx.sv ====
module msg_tx (
	input logic clk_sys,
	input logic cl_reset,
	input iobus_pkg::msg_t tx_msg,
	input logic tx_send,
	input logic link_busy,
	output logic [7:0] tx_byte,
	output logic tx_strobe,
	output logic tx_busy
);
	import iobus_pkg::*;

	msg_t msg_q;	// message being sent
	logic on_cmd;	// command byte not yet out
	logic [2:0] left;	// argument bytes still to send
	logic [2:0] slot;

	assign tx_strobe = tx_busy & ~link_busy;

	always_comb begin
		if (on_cmd) begin
			tx_byte = msg_q.cmd;
		end else begin
			case (slot)
				3'd0: tx_byte = msg_q.a1;
				3'd1: tx_byte = msg_q.a2[15:8];
				3'd2: tx_byte = msg_q.a2[7:0];
				3'd3: tx_byte = msg_q.a3[15:8];
				default: tx_byte = msg_q.a3[7:0];
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tx_send)
			msg_q <= tx_msg;
	end

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			tx_busy <= 1'b0;
			on_cmd <= 1'b0;
			left <= 3'd0;
			slot <= 3'd0;
		end else if (tx_send) begin
			tx_busy <= 1'b1;
			on_cmd <= 1'b1;
			left <= msg_arg_len(tx_msg.cmd);
			slot <= msg_arg_first(tx_msg.cmd);
		end else if (tx_strobe) begin
			if (on_cmd) begin
				on_cmd <= 1'b0;
				if (left == 3'd0)
					tx_busy <= 1'b0;	// no arguments
			end else begin
				left <= left - 3'd1;
				slot <= slot + 3'd1;
				if (left == 3'd1)
					tx_busy <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/iobus_ctrl.sv ====
`include "iobus_config.svh"

module iobus_ctrl (
	input logic clk_sys,
	input logic cl_reset,
	input iobus_pkg::bus_in_t bus_in,
	input logic rcl,
	input logic zw,
	input logic [7:0] local_cmd,
	input iobus_pkg::msg_t rx_msg,
	input iobus_pkg::cmd_flags_t rx_flags,
	input logic rx_done,
	input logic rx_busy,
	input logic tx_busy,
	output logic rx_clear,
	output iobus_pkg::msg_t tx_msg,
	output logic tx_send,
	output logic zg,
	output iobus_pkg::bus_out_t bus_out
);
	import iobus_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_lreq,	// local request sent, waiting for host reply
		st_hresp,	// host reply on the bus
		st_hreq,	// host request, waiting for grant
		st_lresp,	// bus driven, waiting for local reply
		st_engaged,
		st_clear,
		st_wait	// waiting for the transmitter
	} state_t;

	state_t state;
	logic d_ena;	// drive held message onto the bus
	logic rcl_hold;
	logic rx_pend;
	logic rx_ready;
	logic l_req;
	logic l_resp;
	logic h_req;
	logic h_pa;
	logic h_resp;
	logic send_clear;
	logic send_lreq;
	logic send_lresp;
	msg_t local_msg;
	msg_t clear_msg;

	assign l_req = (bus_in.rs | bus_in.rf) & ~bus_in.rad[`IOBUS_LOCAL_ADDR_BIT];
	assign l_resp = bus_in.rok | bus_in.rpe;

	// message complete and not yet released
	assign rx_ready = (rx_done | (rx_pend & ~rx_clear)) & ~rx_busy;
	assign h_req = rx_ready & rx_flags.valid & (rx_flags.w | rx_flags.r | rx_flags.in);
	assign h_pa = rx_ready & rx_flags.valid & rx_flags.pa;
	assign h_resp = rx_ready & rx_flags.valid & ~rx_flags.req;

	assign send_clear = (state == st_idle) & rcl_hold;
	assign send_lreq = (state == st_idle) & ~rcl_hold & l_req;
	assign send_lresp = (state == st_lresp) & l_resp;

	assign local_msg = {local_cmd, 2'b00, bus_in.rqb, bus_in.rpn, bus_in.rnb, bus_in.rad,
		bus_in.rdt};
	assign clear_msg = {`IOBUS_MSG_REQ, `IOBUS_CMD_CL, 3'b000, 40'd0};

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset)
			rx_pend <= 1'b0;
		else if (rx_done)
			rx_pend <= 1'b1;
		else if (rx_clear)
			rx_pend <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (send_clear)
			tx_msg <= clear_msg;
		else if (send_lreq | send_lresp)
			tx_msg <= local_msg;	// request or reply, same fields
	end

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			state <= st_idle;
			d_ena <= 1'b0;
			zg <= 1'b0;
			tx_send <= 1'b0;
			rx_clear <= 1'b0;
			rcl_hold <= 1'b0;
		end else begin
			tx_send <= 1'b0;
			rx_clear <= 1'b0;
			if (rcl)
				rcl_hold <= 1'b1;
			case (state)
				st_idle: begin
					if (send_clear | send_lreq) begin
						tx_send <= 1'b1;
						state <= send_clear ? st_clear : st_lreq;
					end else if (h_pa) begin
						d_ena <= 1'b1;	// interrupt only, no reply
						state <= st_wait;
					end else if (h_req) begin
						zg <= 1'b1;
						state <= st_hreq;
					end else if (rx_ready) begin
						rx_clear <= 1'b1;	// stray message
					end
				end
				st_lreq: begin
					if (h_resp) begin
						d_ena <= 1'b1;
						state <= st_hresp;
					end else if (h_req & ~zw) begin
						state <= st_engaged;
					end else if (rx_ready & ~h_req) begin
						rx_clear <= 1'b1;
					end
				end
				st_hresp: begin
					if (!l_req) begin
						d_ena <= 1'b0;
						rx_clear <= 1'b1;
						state <= st_idle;
					end
				end
				st_hreq: begin
					if (zw) begin
						d_ena <= 1'b1;
						state <= st_lresp;
					end
				end
				st_lresp: begin
					if (send_lresp) begin
						tx_send <= 1'b1;
						d_ena <= 1'b0;
						state <= st_wait;
					end
				end
				st_engaged: begin
					if (!l_req) begin	// serve the host request now
						zg <= 1'b1;
						state <= st_hreq;
					end
				end
				st_clear: begin
					if (!rcl && !tx_busy && !tx_send) begin
						rcl_hold <= 1'b0;
						state <= st_idle;
					end
				end
				st_wait: begin
					d_ena <= 1'b0;
					if (!tx_busy && !tx_send) begin
						zg <= 1'b0;
						rx_clear <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// bus drivers
	always_comb begin
		bus_out.dpa = d_ena & rx_flags.pa;
		bus_out.dw = d_ena & rx_flags.w;
		bus_out.dr = d_ena & rx_flags.r;
		bus_out.din = d_ena & rx_flags.in;
		bus_out.dok = d_ena & rx_flags.ok;
		bus_out.den = (d_ena & rx_flags.en) | (state == st_engaged);
		bus_out.dpe = d_ena & rx_flags.pe;
		bus_out.dpn = d_ena & rx_msg.a1[4];
		bus_out.dnb = d_ena ? rx_msg.a1[3:0] : 4'd0;
		bus_out.dad = d_ena ? rx_msg.a2 : 16'd0;
		bus_out.ddt = d_ena ? rx_msg.a3 : 16'd0;
	end

endmodule

// ==== hw/iobus.sv ====
module iobus (
	input logic clk_sys,
	input logic cl_reset,
	input logic [7:0] rx_byte,
	input logic rx_strobe,
	output logic [7:0] tx_byte,
	output logic tx_strobe,
	input logic link_busy,
	input iobus_pkg::bus_in_t bus_in,
	output iobus_pkg::bus_out_t bus_out,
	input logic rcl,
	input logic zw,
	output logic zg
);
	import iobus_pkg::*;

	msg_t rx_msg;
	msg_t tx_msg;
	cmd_flags_t rx_flags;
	logic [7:0] local_cmd;
	logic rx_done;
	logic rx_busy;
	logic rx_clear;
	logic tx_send;
	logic tx_busy;

	cmd_codec u_codec (
		.bus_in(bus_in),
		.rx_cmd(rx_msg.cmd),
		.local_cmd(local_cmd),
		.rx_flags(rx_flags)
	);

	msg_rx u_rx (
		.clk_sys(clk_sys),
		.cl_reset(cl_reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.rx_clear(rx_clear),
		.rx_msg(rx_msg),
		.rx_done(rx_done),
		.rx_busy(rx_busy)
	);

	msg_tx u_tx (
		.clk_sys(clk_sys),
		.cl_reset(cl_reset),
		.tx_msg(tx_msg),
		.tx_send(tx_send),
		.link_busy(link_busy),
		.tx_byte(tx_byte),
		.tx_strobe(tx_strobe),
		.tx_busy(tx_busy)
	);

	iobus_ctrl u_ctrl (
		.clk_sys(clk_sys),
		.cl_reset(cl_reset),
		.bus_in(bus_in),
		.rcl(rcl),
		.zw(zw),
		.local_cmd(local_cmd),
		.rx_msg(rx_msg),
		.rx_flags(rx_flags),
		.rx_done(rx_done),
		.rx_busy(rx_busy),
		.tx_busy(tx_busy),
		.rx_clear(rx_clear),
		.tx_msg(tx_msg),
		.tx_send(tx_send),
		.zg(zg),
		.bus_out(bus_out)
	);

endmodule

// ==== sim/iobus_tb_checks.svh ====
`ifndef IOBUS_TB_CHECKS_SVH
`define IOBUS_TB_CHECKS_SVH

int err_value = 0;	// wrong values
int err_wait = 0;	// waits that ran out

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("CHECK FAILED %s byte: expected %h actual %h", name, exp, act);
		err_value++;
	end
endtask

task automatic check_msg(input string name, input msg_t exp, input msg_t act);
	if (act !== exp) begin
		$display("CHECK FAILED %s message: expected %h actual %h", name, exp, act);
		err_value++;
	end
endtask

task automatic check_bus(input string name, input bus_out_t exp, input bus_out_t act);
	if (act !== exp) begin
		$display("CHECK FAILED %s bus_out: expected %h actual %h", name, exp, act);
		err_value++;
	end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("CHECK FAILED %s level: expected %b actual %b", name, exp, act);
		err_value++;
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("CHECK FAILED %s count: expected %0d actual %0d", name, exp, act);
		err_value++;
	end
endtask

`endif

// ==== sim/iobus_tb.sv ====
`include "iobus_config.svh"

module iobus_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import iobus_pkg::*;

	`include "iobus_tb_checks.svh"

	localparam int N_ENTRIES = 10;
	localparam int LIMIT = N_ENTRIES * 200;
	localparam int WAIT_MAX = 100;	// cycles for one wait
	localparam int K_LOCAL = 0;
	localparam int K_HOST = 1;
	localparam int K_PA = 2;
	localparam int K_CLEAR = 3;
	localparam int K_ENGAGE = 4;
	localparam int C_ZG_HI = 0;
	localparam int C_ZG_LO = 1;
	localparam int C_DRIVE = 2;
	localparam int C_REPLY = 3;
	localparam int C_IDLE = 4;
	localparam int C_DEN = 5;

	logic clk_sys;
	logic cl_reset;
	logic [7:0] rx_byte;
	logic rx_strobe;
	logic [7:0] tx_byte;
	logic tx_strobe;
	logic link_busy;
	bus_in_t bus_in;
	bus_out_t bus_out;
	logic rcl;
	logic zw;
	logic zg;

	logic [7:0] tx_bytes[$];	// everything the link received
	int busy_left = 0;
	int cycle_cnt = 0;

	// stimulus table with one column per array
	string t_name[N_ENTRIES];
	int t_kind[N_ENTRIES];
	msg_t t_host[N_ENTRIES];
	int t_host_n[N_ENTRIES];	// -1 when the host sends nothing
	bus_in_t t_req[N_ENTRIES];
	bus_in_t t_rep[N_ENTRIES];
	msg_t t_msg1[N_ENTRIES];
	int t_n1[N_ENTRIES];	// -1 when no message is expected
	msg_t t_msg2[N_ENTRIES];
	int t_n2[N_ENTRIES];
	bus_out_t t_bus1[N_ENTRIES];
	bus_out_t t_bus2[N_ENTRIES];

	iobus u_dut (
		.clk_sys(clk_sys),
		.cl_reset(cl_reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.tx_byte(tx_byte),
		.tx_strobe(tx_strobe),
		.link_busy(link_busy),
		.bus_in(bus_in),
		.bus_out(bus_out),
		.rcl(rcl),
		.zw(zw),
		.zg(zg)
	);

	always #20 clk_sys = ~clk_sys;

	// link model with random back-pressure after each byte
	initial begin
		void'($urandom(32'h5fb2_ec18));
		forever begin
			@(negedge clk_sys);
			if (tx_strobe === 1'b1) begin
				tx_bytes.push_back(tx_byte);
				busy_left = $urandom_range(3, 0);
			end
			@(posedge clk_sys);
			#5;
			if (busy_left > 0) begin
				link_busy = 1'b1;
				busy_left--;
			end else begin
				link_busy = 1'b0;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT) begin
			$display("run stopped after the %0d-cycle limit", LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic msg_t mk_msg(input logic req, input logic [3:0] code,
		input logic [7:0] a1, input logic [15:0] a2, input logic [15:0] a3);
		msg_t m;
		m.cmd = {req, code, 3'b000};
		m.a1 = a1;
		m.a2 = a2;
		m.a3 = a3;
		return m;
	endfunction

	// an OK response carries only a3
	function automatic int first_slot(input logic [7:0] cmd);
		return (cmd == {`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 3'b000}) ? 3 : 0;
	endfunction

	function automatic logic [7:0] wire_byte(input msg_t m, input int idx);
		int slot;
		if (idx == 0)
			return m.cmd;
		slot = first_slot(m.cmd) + idx - 1;
		case (slot)
			0: return m.a1;
			1: return m.a2[15:8];
			2: return m.a2[7:0];
			3: return m.a3[15:8];
			default: return m.a3[7:0];
		endcase
	endfunction

	function automatic msg_t rebuild(input int base, input int nargs);
		msg_t m;
		int slot;
		m = '0;
		m.cmd = tx_bytes[base];
		for (int k = 0; k < nargs; k++) begin
			slot = first_slot(m.cmd) + k;
			case (slot)
				0: m.a1 = tx_bytes[base + 1 + k];
				1: m.a2[15:8] = tx_bytes[base + 1 + k];
				2: m.a2[7:0] = tx_bytes[base + 1 + k];
				3: m.a3[15:8] = tx_bytes[base + 1 + k];
				default: m.a3[7:0] = tx_bytes[base + 1 + k];
			endcase
		end
		return m;
	endfunction

	function automatic logic cond_met(input int c);
		case (c)
			C_ZG_HI: return zg;
			C_ZG_LO: return ~zg;
			C_DRIVE: return bus_out.dw | bus_out.dr | bus_out.din;
			C_REPLY: return bus_out.dok | bus_out.den | bus_out.dpe;
			C_IDLE: return bus_out == '0;
			default: return bus_out.den;
		endcase
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic wait_until(input string name, input int c);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!cond_met(c) && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cond_met(c)) begin
			$display("%s: bus condition %0d never came up", name, c);
			err_wait++;
		end
	endtask

	task automatic wait_tx(input string name, input int target);
		int n;
		n = 0;
		while (tx_bytes.size() < target && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		if (tx_bytes.size() < target) begin
			$display("%s: link got %0d bytes, waited for %0d", name, tx_bytes.size(), target);
			err_wait++;
		end
	endtask

	task automatic send_msg(input msg_t m, input int nargs);
		step();
		for (int i = 0; i <= nargs; i++) begin
			rx_byte = wire_byte(m, i);
			rx_strobe = 1'b1;
			step();
		end
		rx_strobe = 1'b0;
	endtask

	task automatic check_tx(input string name, input int base, input msg_t exp, input int nargs);
		if (tx_bytes.size() < base + nargs + 1)
			return;
		for (int i = 0; i <= nargs; i++)
			check_byte(name, wire_byte(exp, i), tx_bytes[base + i]);
		check_msg(name, exp, rebuild(base, nargs));
	endtask

	task automatic fill_table();
		for (int i = 0; i < N_ENTRIES; i++) begin
			t_host_n[i] = -1;
			t_req[i] = '0;
			t_rep[i] = '0;
			t_n1[i] = -1;
			t_n2[i] = -1;
			t_bus1[i] = '0;
			t_bus2[i] = '0;
		end
		t_name[0] = "store";
		t_kind[0] = K_LOCAL;
		t_req[0].rs = 1'b1;
		t_req[0].rpn = 1'b1;
		t_req[0].rnb = 4'd5;
		t_req[0].rad = 16'h1234;
		t_req[0].rdt = 16'habcd;
		t_msg1[0] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_W, 8'h15, 16'h1234, 16'habcd);
		t_n1[0] = 5;
		t_host[0] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 8'h00, 16'h0000, 16'h0000);
		t_host_n[0] = 2;
		t_bus1[0].dok = 1'b1;
		t_name[1] = "store_local";	// address bit 15 keeps it on the bus
		t_kind[1] = K_LOCAL;
		t_req[1].rs = 1'b1;
		t_req[1].rad = 16'h8010;
		t_req[1].rdt = 16'h0001;
		t_name[2] = "fetch_ok";
		t_kind[2] = K_LOCAL;
		t_req[2].rf = 1'b1;
		t_req[2].rnb = 4'd3;
		t_req[2].rad = 16'h0456;
		t_msg1[2] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_R, 8'h03, 16'h0456, 16'h0000);
		t_n1[2] = 3;
		t_host[2] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 8'h00, 16'h0000, 16'h5a5a);
		t_host_n[2] = 2;
		t_bus1[2].dok = 1'b1;
		t_bus1[2].ddt = 16'h5a5a;
		t_name[3] = "fetch_en";
		t_kind[3] = K_LOCAL;
		t_req[3].rf = 1'b1;
		t_req[3].rad = 16'h0789;
		t_msg1[3] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_R, 8'h00, 16'h0789, 16'h0000);
		t_n1[3] = 3;
		t_host[3] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_EN, 8'h00, 16'h0000, 16'h0000);
		t_host_n[3] = 0;
		t_bus1[3].den = 1'b1;
		t_name[4] = "host_w";
		t_kind[4] = K_HOST;
		t_host[4] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_W, 8'h07, 16'h2468, 16'h1357);
		t_host_n[4] = 5;
		t_bus1[4].dw = 1'b1;
		t_bus1[4].dnb = 4'd7;
		t_bus1[4].dad = 16'h2468;
		t_bus1[4].ddt = 16'h1357;
		t_rep[4].rok = 1'b1;
		t_rep[4].rdt = 16'hbeef;
		t_msg2[4] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 8'h00, 16'h0000, 16'hbeef);
		t_n2[4] = 2;
		t_name[5] = "host_r_pe";
		t_kind[5] = K_HOST;
		t_host[5] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_R, 8'h12, 16'h0100, 16'h0000);
		t_host_n[5] = 3;
		t_bus1[5].dr = 1'b1;
		t_bus1[5].dpn = 1'b1;
		t_bus1[5].dnb = 4'd2;
		t_bus1[5].dad = 16'h0100;
		t_rep[5].rpe = 1'b1;
		t_msg2[5] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_PE, 8'h00, 16'h0000, 16'h0000);
		t_n2[5] = 0;
		t_name[6] = "host_pa";
		t_kind[6] = K_PA;
		t_host[6] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_PA, 8'h0c, 16'h0000, 16'h0000);
		t_host_n[6] = 1;
		t_bus1[6].dpa = 1'b1;
		t_bus1[6].dnb = 4'hc;
		t_name[7] = "clear";
		t_kind[7] = K_CLEAR;
		t_msg1[7] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_CL, 8'h00, 16'h0000, 16'h0000);
		t_n1[7] = 0;
		t_name[8] = "store_after_clear";
		t_kind[8] = K_LOCAL;
		t_req[8].rs = 1'b1;
		t_req[8].rqb = 1'b1;
		t_req[8].rnb = 4'd9;
		t_req[8].rad = 16'h0a0b;
		t_req[8].rdt = 16'h3c3c;
		t_msg1[8] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_W, 8'h29, 16'h0a0b, 16'h3c3c);
		t_n1[8] = 5;
		t_host[8] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 8'h00, 16'h0000, 16'h0000);
		t_host_n[8] = 2;
		t_bus1[8].dok = 1'b1;
		t_name[9] = "engaged";
		t_kind[9] = K_ENGAGE;
		t_req[9].rf = 1'b1;
		t_req[9].rnb = 4'd1;
		t_req[9].rad = 16'h0042;
		t_msg1[9] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_R, 8'h01, 16'h0042, 16'h0000);
		t_n1[9] = 3;
		t_host[9] = mk_msg(`IOBUS_MSG_REQ, `IOBUS_CMD_IN, 8'h01, 16'h0077, 16'h0000);
		t_host_n[9] = 3;
		t_bus1[9].den = 1'b1;
		t_bus2[9].din = 1'b1;
		t_bus2[9].dnb = 4'd1;
		t_bus2[9].dad = 16'h0077;
		t_rep[9].rok = 1'b1;
		t_rep[9].rdt = 16'h4321;
		t_msg2[9] = mk_msg(`IOBUS_MSG_RESP, `IOBUS_CMD_OK, 8'h00, 16'h0000, 16'h4321);
		t_n2[9] = 2;
	endtask

	// host request served through zg/zw with the reply sent as msg2
	task automatic serve_host(input int i, input int base2, input bus_out_t exp_bus);
		wait_until(t_name[i], C_ZG_HI);
		check_bus(t_name[i], '0, bus_out);	// bus stays quiet until the grant
		step();
		zw = 1'b1;
		wait_until(t_name[i], C_DRIVE);
		check_bus(t_name[i], exp_bus, bus_out);
		step();
		bus_in = t_rep[i];
		wait_until(t_name[i], C_ZG_LO);
		wait_tx(t_name[i], base2 + t_n2[i] + 1);
		check_tx(t_name[i], base2, t_msg2[i], t_n2[i]);
		step();
		bus_in = '0;
		zw = 1'b0;
	endtask

	task automatic run_entry(input int i);
		int base;
		int total;
		int dpa_cnt;
		bus_out_t seen;
		base = tx_bytes.size();
		total = 0;
		if (t_n1[i] >= 0)
			total += t_n1[i] + 1;
		if (t_n2[i] >= 0)
			total += t_n2[i] + 1;
		step();
		case (t_kind[i])
			K_LOCAL: begin
				bus_in = t_req[i];
				if (t_n1[i] >= 0) begin
					wait_tx(t_name[i], base + t_n1[i] + 1);
					check_tx(t_name[i], base, t_msg1[i], t_n1[i]);
				end
				if (t_host_n[i] >= 0) begin
					send_msg(t_host[i], t_host_n[i]);
					wait_until(t_name[i], C_REPLY);
				end else begin
					repeat (20) @(negedge clk_sys);
				end
				check_bus(t_name[i], t_bus1[i], bus_out);
				step();
				bus_in = '0;
				wait_until(t_name[i], C_IDLE);
			end
			K_HOST: begin
				send_msg(t_host[i], t_host_n[i]);
				serve_host(i, base, t_bus1[i]);
			end
			K_PA: begin
				send_msg(t_host[i], t_host_n[i]);
				dpa_cnt = 0;
				seen = '0;
				repeat (20) begin
					@(negedge clk_sys);
					if (bus_out.dpa) begin
						if (dpa_cnt == 0)
							seen = bus_out;
						dpa_cnt++;
					end
				end
				check_bus(t_name[i], t_bus1[i], seen);
				check_count({t_name[i], " dpa cycles"}, 1, dpa_cnt);
			end
			K_CLEAR: begin
				rcl = 1'b1;
				step();
				rcl = 1'b0;
				wait_tx(t_name[i], base + 1);
				check_tx(t_name[i], base, t_msg1[i], t_n1[i]);
			end
			default: begin
				bus_in = t_req[i];
				wait_tx(t_name[i], base + t_n1[i] + 1);
				check_tx(t_name[i], base, t_msg1[i], t_n1[i]);
				send_msg(t_host[i], t_host_n[i]);
				wait_until(t_name[i], C_DEN);
				check_bus(t_name[i], t_bus1[i], bus_out);
				check_level(t_name[i], 1'b0, zg);	// no grant request while engaged
				step();
				bus_in = '0;
				serve_host(i, base + t_n1[i] + 1, t_bus2[i]);
			end
		endcase
		repeat (10) @(negedge clk_sys);	// nothing more may arrive
		check_count({t_name[i], " link bytes"}, total, tx_bytes.size() - base);
	endtask

	initial begin
		clk_sys = 1'b0;
		cl_reset = 1'b1;
		rx_byte = 8'd0;
		rx_strobe = 1'b0;
		link_busy = 1'b0;
		bus_in = '0;
		rcl = 1'b0;
		zw = 1'b0;
		fill_table();
		repeat (3) @(posedge clk_sys);
		#5;
		cl_reset = 1'b0;
		@(negedge clk_sys);
		check_level("reset zg", 1'b0, zg);
		check_level("reset tx_strobe", 1'b0, tx_strobe);
		check_bus("reset", '0, bus_out);
		for (int i = 0; i < N_ENTRIES; i++)
			run_entry(i);
		$display("errors: %0d wrong values, %0d waits ran out", err_value, err_wait);
		if (err_value + err_wait == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== iobus.f ====
+incdir+hw
+incdir+sim
hw/iobus_pkg.sv
hw/cmd_codec.sv
hw/msg_rx.sv
hw/msg_tx.sv
hw/iobus_ctrl.sv
hw/iobus.sv
sim/iobus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the iobus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f iobus.f --top-module iobus_tb \
	--Mdir obj_dir -o iobus_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/iobus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
	exit 0
fi
exit 1
